//--- flist.f
+incdir+include
verilog/nes_cart_pkg.sv
verilog/nes_load_pkg.sv
verilog/ines_header_if.sv
verilog/ines_header_decoder.sv
verilog/rom_load_sequencer.sv
verilog/cheat_code_assembler.sv
verilog/nes_cart_loader.sv
verif/nes_cart_loader_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the loader testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	-f flist.f --top-module nes_cart_loader_tb -o nes_cart_loader_sim

./obj_dir/nes_cart_loader_sim | tee sim.log

if grep -q "Result: FAILED" sim.log; then
	exit 1
fi
exit 0

//--- verif/nes_cart_loader_tb.sv
//////////////////////////////
// Self-checking testbench for the cartridge loader
// Runs a table of downloads against a memory model and a cheat checker
//////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module nes_cart_loader_tb;

	localparam int          NUM_CASES      = 6;
	localparam int          PRG_PAGE_BYTES = 16384;
	localparam int          CHR_PAGE_BYTES = 8192;
	localparam logic [21:0] CHR_BASE       = 22'h200000;
	localparam logic [7:0]  CHEAT_TYPE     = 8'hFF;
	localparam int          STREAM_TIMEOUT = 100;
	localparam int          DONE_TIMEOUT   = 200;

	// One download; header byte 0 sits in the top byte
	typedef struct packed {
		logic [7:0]   file_type;
		logic [127:0] header;
		logic         invert;
		logic         stall;
		logic [31:0]  exp_flags;
		logic         exp_error;
	} load_case_t;

	logic          clk = 1'b0;
	logic          reset_nes;
	logic          download;
	logic [7:0]    file_type;
	logic          invert_mirroring;
	logic          in_valid;
	logic [7:0]    in_data;
	logic          in_ready;
	logic          mem_valid;
	logic [21:0]   mem_addr;
	logic [7:0]    mem_data;
	logic          mem_ready = 1'b0;
	logic [31:0]   mapper_flags;
	logic          busy;
	logic          done;
	logic          error;
	logic          cheat_valid;
	logic [127:0]  cheat_code;

	load_case_t    cases [NUM_CASES];
	logic [21:0]   exp_addr_q [$];
	logic [7:0]    exp_data_q [$];
	logic [127:0]  exp_cheat_q [$];
	logic          stall_mode = 1'b0;
	logic          timed_out = 1'b0;
	int unsigned   mismatch_count = 0;
	int unsigned   fail_count = 0;
	int unsigned   write_count = 0;
	int unsigned   cheat_pulses = 0;
	logic          hold_pending = 1'b0;
	logic [21:0]   held_addr;
	logic [7:0]    held_data;
	logic [21:0]   want_addr;
	logic [7:0]    want_data;
	logic [127:0]  want_code;

	always #5 clk = ~clk;

	nes_cart_loader nes_cart_loader_inst (
		.clk              (clk),
		.reset_nes        (reset_nes),
		.download         (download),
		.file_type        (file_type),
		.invert_mirroring (invert_mirroring),
		.in_valid         (in_valid),
		.in_data          (in_data),
		.in_ready         (in_ready),
		.mem_valid        (mem_valid),
		.mem_addr         (mem_addr),
		.mem_data         (mem_data),
		.mem_ready        (mem_ready),
		.mapper_flags     (mapper_flags),
		.busy             (busy),
		.done             (done),
		.error            (error),
		.cheat_valid      (cheat_valid),
		.cheat_code       (cheat_code)
	);

	// Memory side back-pressure, random while stalling
	always @(posedge clk) begin
		#1;
		mem_ready = stall_mode ? (($urandom % 3) != 0) : 1'b1;
	end

	//////////////////////////////
	// Memory model
	//////////////////////////////
	always @(negedge clk) begin
		if (reset_nes) begin
			hold_pending = 1'b0;
		end else begin
			if (hold_pending && (!mem_valid || mem_addr !== held_addr || mem_data !== held_data)) begin
				$display("memory write changed while mem_ready was low");
				fail_count++;
			end
			hold_pending = 1'b0;
			if (mem_valid && mem_ready) begin   // Completes on the coming edge
				write_count++;
				if (exp_addr_q.size() == 0) begin
					$display("unexpected memory write to address %h", mem_addr);
					fail_count++;
				end else begin
					want_addr = exp_addr_q.pop_front();
					want_data = exp_data_q.pop_front();
					if (mem_addr !== want_addr) begin
						$display("mismatch mem_addr: got %h expected %h", mem_addr, want_addr);
						mismatch_count++;
					end
					if (mem_data !== want_data) begin
						$display("mismatch mem_data: got %h expected %h", mem_data, want_data);
						mismatch_count++;
					end
				end
			end else if (mem_valid) begin
				hold_pending = 1'b1;
				held_addr    = mem_addr;
				held_data    = mem_data;
			end
		end
	end

	// Cheat checker
	always @(negedge clk) begin
		if (!reset_nes && cheat_valid) begin
			cheat_pulses++;
			if (exp_cheat_q.size() == 0) begin
				$display("cheat_valid pulsed with no record sent");
				fail_count++;
			end else begin
				want_code = exp_cheat_q.pop_front();
				if (cheat_code !== want_code) begin
					$display("mismatch cheat_code: got %h expected %h", cheat_code, want_code);
					mismatch_count++;
				end
			end
		end
	end

	function automatic logic [7:0] header_byte(input logic [127:0] hdr, input int idx);
		return hdr[127 - 8 * idx -: 8];
	endfunction

	task automatic step_cycle();
		@(posedge clk);
		#1;
	endtask

	// Offer one byte until the DUT takes it
	task automatic send_byte(input logic [7:0] value);
		int unsigned waited;
		logic        taken;
		waited   = 0;
		taken    = 1'b0;
		in_valid = 1'b1;
		in_data  = value;
		while (!taken && !timed_out) begin
			@(negedge clk);
			taken = in_ready;   // Stable until the next edge
			step_cycle();
			waited++;
			if (!taken && waited > STREAM_TIMEOUT) begin
				$display("stream byte not accepted within %0d cycles", STREAM_TIMEOUT);
				fail_count++;
				timed_out = 1'b1;
			end
		end
		in_valid = 1'b0;
	endtask

	task automatic start_download(input logic [7:0] ftype, input logic inv);
		file_type        = ftype;
		invert_mirroring = inv;
		download         = 1'b1;
		step_cycle();
	endtask

	task automatic end_download();
		download = 1'b0;
		step_cycle();
		step_cycle();
	endtask

	task automatic wait_for_done();
		int unsigned waited;
		waited = 0;
		while (!done && !timed_out) begin
			step_cycle();
			waited++;
			if (waited > DONE_TIMEOUT) begin
				$display("done never rose after the download");
				fail_count++;
				timed_out = 1'b1;
			end
		end
	endtask

	task automatic wait_for_cheats(input int unsigned count);
		int unsigned waited;
		waited = 0;
		while (cheat_pulses < count && !timed_out) begin
			step_cycle();
			waited++;
			if (waited > DONE_TIMEOUT) begin
				$display("only %0d of %0d cheat codes arrived", cheat_pulses, count);
				fail_count++;
				timed_out = 1'b1;
			end
		end
	endtask

	//////////////////////////////
	// Cartridge download
	//////////////////////////////
	task automatic run_cart_case(input load_case_t row);
		int unsigned prg_len;
		int unsigned chr_len;
		int unsigned exp_writes;
		logic [7:0]  value;
		stall_mode  = row.stall;
		write_count = 0;
		prg_len     = int'(header_byte(row.header, 4)) * PRG_PAGE_BYTES;
		chr_len     = int'(header_byte(row.header, 5)) * CHR_PAGE_BYTES;
		exp_writes  = row.exp_error ? 0 : prg_len + chr_len;
		start_download(row.file_type, row.invert);
		for (int k = 0; k < 16; k++)
			send_byte(header_byte(row.header, k));
		if (!row.exp_error && busy !== 1'b1) begin
			$display("busy did not rise after a valid header");
			fail_count++;
		end
		if (!row.exp_error) begin
			for (int unsigned n = 0; n < prg_len && !timed_out; n++) begin
				value = 8'($urandom);
				exp_addr_q.push_back(22'(n));
				exp_data_q.push_back(value);
				send_byte(value);
			end
			for (int unsigned n = 0; n < chr_len && !timed_out; n++) begin
				value = 8'($urandom);
				exp_addr_q.push_back(CHR_BASE + 22'(n));
				exp_data_q.push_back(value);
				send_byte(value);
			end
		end
		wait_for_done();
		if (timed_out)
			return;
		if (error !== row.exp_error) begin
			$display("mismatch error: got %h expected %h", error, row.exp_error);
			mismatch_count++;
		end
		if (busy !== 1'b0) begin
			$display("mismatch busy: got %h expected %h", busy, 1'b0);
			mismatch_count++;
		end
		if (mapper_flags !== row.exp_flags) begin
			$display("mismatch mapper_flags: got %h expected %h", mapper_flags, row.exp_flags);
			mismatch_count++;
		end
		if (write_count != exp_writes) begin
			$display("mismatch write_count: got %h expected %h", write_count, exp_writes);
			mismatch_count++;
		end
		if (exp_addr_q.size() != 0) begin
			$display("%0d expected writes were still missing at done", exp_addr_q.size());
			fail_count++;
			exp_addr_q.delete();
			exp_data_q.delete();
		end
		end_download();
	endtask

	//////////////////////////////
	// Cheat download
	//////////////////////////////
	task automatic run_cheat_case(input load_case_t row);
		logic [7:0]   rec [16];
		logic [127:0] code;
		stall_mode   = row.stall;
		write_count  = 0;
		cheat_pulses = 0;
		start_download(row.file_type, row.invert);
		for (int r = 0; r < 2 && !timed_out; r++) begin
			code = '0;
			for (int k = 0; k < 16; k++) begin
				rec[k] = 8'($urandom);
				code[96 - 32 * (k / 4) + 8 * (k % 4) +: 8] = rec[k];   // Field k/4, byte k%4
			end
			exp_cheat_q.push_back(code);
			for (int k = 0; k < 16; k++) begin
				send_byte(rec[k]);
				if (busy !== 1'b0) begin
					$display("busy rose during a cheat download");
					fail_count++;
				end
			end
		end
		wait_for_cheats(2);
		if (timed_out)
			return;
		if (write_count != 0) begin
			$display("mismatch write_count: got %h expected %h", write_count, 0);
			mismatch_count++;
		end
		end_download();
	endtask

	initial begin
		int unsigned seed_discard;
		seed_discard     = $urandom(32'h3692);
		reset_nes        = 1'b1;
		download         = 1'b0;
		file_type        = 8'h00;
		invert_mirroring = 1'b0;
		in_valid         = 1'b0;
		in_data          = 8'h00;

		// file_type, header, invert, stall, flags, error
		cases[0] = '{8'h00, 128'h4E45531A_01011200_00000000_00000000, 1'b1, 1'b0,
		             32'h02004001, 1'b0};   // Mapper 1 with battery
		cases[1] = '{8'h00, 128'h4E45531A_01004018_05000700_00000019, 1'b0, 1'b1,
		             32'h5C0A8014, 1'b0};   // NES 2.0, no CHR
		cases[2] = '{8'h00, 128'h4E45531A_01023140_00000000_44000000, 1'b0, 1'b1,
		             32'h00004803, 1'b0};   // Dirty 1.0 header
		cases[3] = '{8'h00, 128'h4E45531B_01010000_00000000_00000000, 1'b0, 1'b0,
		             32'h00000000, 1'b1};   // Bad magic
		cases[4] = '{8'h00, 128'h4E45531A_01010400_00000000_00000000, 1'b0, 1'b0,
		             32'h00000000, 1'b1};   // Trainer
		cases[5] = '{CHEAT_TYPE, 128'h0, 1'b0, 1'b1, 32'h00000000, 1'b0};

		repeat (5) @(posedge clk);
		#1;
		reset_nes = 1'b0;
		if ({mem_valid, busy, done, error, cheat_valid, in_ready} !== 6'b000000) begin
			$display("outputs not all low after reset");
			fail_count++;
		end

		for (int i = 0; i < NUM_CASES; i++) begin
			if (timed_out)
				break;
			if (cases[i].file_type == CHEAT_TYPE)
				run_cheat_case(cases[i]);
			else
				run_cart_case(cases[i]);
		end

		$display("errors: %0d mismatches, %0d other failures", mismatch_count, fail_count);
		if (mismatch_count == 0 && fail_count == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog/nes_cart_loader.sv
//////////////////////////////
// Cartridge loader top level
// Takes the download stream, writes ROM and reports mapper flags and cheats
//////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module nes_cart_loader import nes_cart_pkg::*, nes_load_pkg::*; (
	input  wire logic       clk,
	input  wire logic       reset_nes,
	input  wire logic       download,
	input  wire ines_byte_t file_type,
	input  wire logic       invert_mirroring,
	input  wire logic       in_valid,
	input  wire ines_byte_t in_data,
	output logic            in_ready,
	output logic            mem_valid,
	output rom_addr_t       mem_addr,
	output ines_byte_t      mem_data,
	input  wire logic       mem_ready,
	output mapper_flags_t   mapper_flags,
	output logic            busy,
	output logic            done,
	output logic            error,
	output logic            cheat_valid,
	output cheat_code_t     cheat_code
);

	logic         cheat_we;
	cheat_index_t cheat_index;
	ines_byte_t   cheat_byte;

	ines_header_if hdr_if (.invert_mirroring(invert_mirroring));

	assign mapper_flags = hdr_if.mapper_flags;

	rom_load_sequencer rom_load_sequencer_inst (
		.clk         (clk),
		.reset_nes   (reset_nes),
		.download    (download),
		.file_type   (file_type),
		.in_valid    (in_valid),
		.in_data     (in_data),
		.in_ready    (in_ready),
		.hdr         (hdr_if),
		.mem_valid   (mem_valid),
		.mem_addr    (mem_addr),
		.mem_data    (mem_data),
		.mem_ready   (mem_ready),
		.busy        (busy),
		.done        (done),
		.error       (error),
		.cheat_we    (cheat_we),
		.cheat_index (cheat_index),
		.cheat_byte  (cheat_byte)
	);

	ines_header_decoder ines_header_decoder_inst (
		.clk (clk),
		.hdr (hdr_if)
	);

	cheat_code_assembler cheat_code_assembler_inst (
		.clk         (clk),
		.reset_nes   (reset_nes),
		.cheat_we    (cheat_we),
		.cheat_index (cheat_index),
		.cheat_byte  (cheat_byte),
		.cheat_valid (cheat_valid),
		.cheat_code  (cheat_code)
	);

endmodule

`default_nettype wire

//--- verilog/cheat_code_assembler.sv
//////////////////////////////
// Builds a 128-bit cheat code from 16 record bytes
// cheat_valid pulses once per completed record
//////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "nes_loader_defines.svh"

module cheat_code_assembler import nes_cart_pkg::*, nes_load_pkg::*; (
	input  wire logic         clk,
	input  wire logic         reset_nes,
	input  wire logic         cheat_we,
	input  wire cheat_index_t cheat_index,
	input  wire ines_byte_t   cheat_byte,
	output logic              cheat_valid,
	output cheat_code_t       cheat_code
);

	logic [6:0] byte_lsb;

	// Field 0 sits at the top, byte 0 of a field at its bottom
	assign byte_lsb = {~cheat_index[3:2], cheat_index[1:0], 3'b000};

	always_ff @(posedge clk) begin
		if (cheat_we)
			cheat_code[byte_lsb +: 8] <= cheat_byte;
	end

	always_ff @(posedge clk) begin
		if (reset_nes)
			cheat_valid <= 1'b0;
		else
			cheat_valid <= cheat_we &&
			               (cheat_index == cheat_index_t'(`CHEAT_RECORD_BYTES - 1));
	end

	a_single_pulse: assert property (@(posedge clk) disable iff (reset_nes)
		cheat_valid |=> !cheat_valid)
		else $error("cheat_valid high two cycles in a row");

endmodule

`default_nettype wire

//--- verilog/rom_load_sequencer.sv
//////////////////////////////
// Download FSM of the loader
// Routes stream bytes to the header, the cheat assembler or the ROM write port
//////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "nes_loader_defines.svh"

module rom_load_sequencer import nes_cart_pkg::*, nes_load_pkg::*; (
	input  wire logic        clk,
	input  wire logic        reset_nes,
	input  wire logic        download,
	input  wire ines_byte_t  file_type,
	input  wire logic        in_valid,
	input  wire ines_byte_t  in_data,
	output logic             in_ready,
	ines_header_if.sequencer hdr,
	output logic             mem_valid,
	output rom_addr_t        mem_addr,
	output ines_byte_t       mem_data,
	input  wire logic        mem_ready,
	output logic             busy,
	output logic             done,
	output logic             error,
	output logic             cheat_we,
	output cheat_index_t     cheat_index,
	output ines_byte_t       cheat_byte
);

	load_state_t   state;
	logic          download_d;
	logic          download_start;
	logic          accept;
	logic          load_byte;
	header_index_t hdr_cnt;
	cheat_index_t  cheat_cnt;
	rom_addr_t     load_addr;
	byte_count_t   bytes_left;
	byte_count_t   prg_bytes;
	byte_count_t   chr_bytes;

	assign download_start = download && !download_d;
	assign prg_bytes      = byte_count_t'(hdr.prg_pages) << `PRG_PAGE_SHIFT;
	assign chr_bytes      = byte_count_t'(hdr.chr_pages) << `CHR_PAGE_SHIFT;

	always_comb begin
		case (state)
			S_HEADER, S_CHEAT: in_ready = 1'b1;
			S_PRG, S_CHR:      in_ready = !mem_valid || mem_ready;   // Slot free next edge
			default:           in_ready = 1'b0;
		endcase
	end

	assign accept    = in_valid && in_ready;
	assign load_byte = accept && !download_start && ((state == S_PRG) || (state == S_CHR));

	// Header and cheat byte routing
	assign hdr.hdr_we    = accept && (state == S_HEADER);
	assign hdr.hdr_index = hdr_cnt;
	assign hdr.hdr_byte  = in_data;
	assign cheat_we      = accept && (state == S_CHEAT);
	assign cheat_index   = cheat_cnt;
	assign cheat_byte    = in_data;

	//////////////////////////////
	// Control FSM
	//////////////////////////////
	always_ff @(posedge clk) begin
		if (reset_nes) begin
			state      <= S_IDLE;
			download_d <= 1'b0;
			hdr_cnt    <= '0;
			cheat_cnt  <= '0;
			load_addr  <= '0;
			bytes_left <= '0;
			mem_valid  <= 1'b0;
			busy       <= 1'b0;
			done       <= 1'b0;
			error      <= 1'b0;
		end else begin
			download_d <= download;
			if (mem_valid && mem_ready)
				mem_valid <= 1'b0;
			if (download_start) begin
				hdr_cnt   <= '0;
				cheat_cnt <= '0;
				busy      <= 1'b0;
				done      <= 1'b0;
				error     <= 1'b0;
				state     <= (file_type == `CHEAT_FILE_TYPE) ? S_CHEAT : S_HEADER;
			end else begin
				case (state)
					S_HEADER: if (accept) begin
						hdr_cnt <= hdr_cnt + 1'b1;
						if (hdr_cnt == header_index_t'(`INES_HEADER_BYTES - 1)) begin
							if (!hdr.header_ok) begin
								state <= S_ERROR;
								error <= 1'b1;
								done  <= 1'b1;
							end else begin
								busy <= 1'b1;
								if (prg_bytes != '0) begin
									state      <= S_PRG;
									load_addr  <= '0;
									bytes_left <= prg_bytes;
								end else if (chr_bytes != '0) begin
									state      <= S_CHR;
									load_addr  <= `CHR_BASE_ADDR;
									bytes_left <= chr_bytes;
								end else begin
									state <= S_DONE;
								end
							end
						end
					end
					S_PRG, S_CHR: if (load_byte) begin
						mem_valid  <= 1'b1;
						load_addr  <= load_addr + 1'b1;
						bytes_left <= bytes_left - 1'b1;
						if (bytes_left == byte_count_t'(1)) begin
							if ((state == S_PRG) && (chr_bytes != '0)) begin
								state      <= S_CHR;
								load_addr  <= `CHR_BASE_ADDR;
								bytes_left <= chr_bytes;
							end else begin
								state <= S_DONE;
							end
						end
					end
					S_CHEAT: begin
						if (accept) begin
							if (cheat_cnt == cheat_index_t'(`CHEAT_RECORD_BYTES - 1))
								cheat_cnt <= '0;
							else
								cheat_cnt <= cheat_cnt + 1'b1;
						end
						if (!download)
							state <= S_IDLE;
					end
					S_DONE: if (!mem_valid || mem_ready) begin   // Last write drained
						done <= 1'b1;
						busy <= 1'b0;
					end
					default: ;
				endcase
			end
		end
	end

	// Write register payload
	always_ff @(posedge clk) begin
		if (load_byte) begin
			mem_addr <= load_addr;
			mem_data <= in_data;
		end
	end

	a_mem_hold: assert property (@(posedge clk) disable iff (reset_nes)
		(mem_valid && !mem_ready) |=> (mem_valid && $stable(mem_addr) && $stable(mem_data)))
		else $error("memory write changed while stalled");

endmodule

`default_nettype wire

//--- verilog/ines_header_decoder.sv
//////////////////////////////
// Keeps the 16 iNES header bytes and decodes them
// Outputs are combinational and settle once byte 15 is stored
//////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "nes_loader_defines.svh"

module ines_header_decoder import nes_cart_pkg::*, nes_load_pkg::*; (
	input wire logic      clk,
	ines_header_if.decoder hdr
);

	ines_byte_t hdr_mem [`INES_HEADER_BYTES];

	header_index_t next_index;   // Slot after the last byte written
	logic       is_nes20;
	logic       is_dirty;
	logic       tail_nonzero;
	logic       piano;
	logic [3:0] mapper_hi;
	logic [7:0] mapper_num;
	logic [7:0] submapper;
	logic [3:0] prg_ram_shift;
	size_code_t prg_size;
	size_code_t chr_size;

	// Smallest n with count <= 2**n, saturating at 7
	function automatic size_code_t size_code(input page_count_t count);
		size_code_t code;
		code = 3'd7;
		for (int n = 6; n >= 0; n--) begin
			if ({1'b0, count} <= (9'd1 << n))
				code = size_code_t'(n);
		end
		return code;
	endfunction

	always_ff @(posedge clk) begin
		if (hdr.hdr_we) begin
			hdr_mem[hdr.hdr_index] <= hdr.hdr_byte;
			next_index             <= hdr.hdr_index + 1'b1;
		end
	end

	//////////////////////////////
	// Validity and page counts
	//////////////////////////////
	assign hdr.header_ok = (hdr_mem[0] == `INES_MAGIC0) && (hdr_mem[1] == `INES_MAGIC1) &&
	                       (hdr_mem[2] == `INES_MAGIC2) && (hdr_mem[3] == `INES_MAGIC3) &&
	                       !hdr_mem[6][2];   // Trainers not supported
	assign hdr.prg_pages = hdr_mem[4];
	assign hdr.chr_pages = hdr_mem[5];

	//////////////////////////////
	// Mapper flag word
	//////////////////////////////
	assign is_nes20     = (hdr_mem[7][3:2] == 2'b10);
	assign tail_nonzero = |{hdr_mem[10], hdr_mem[11], hdr_mem[12],
	                        hdr_mem[13], hdr_mem[14], hdr_mem[15]};
	// Old dumps often carry junk in the padding bytes
	assign is_dirty     = !is_nes20 && ((|hdr_mem[9][7:1]) || tail_nonzero);

	assign mapper_hi     = is_dirty ? 4'h0 : hdr_mem[7][7:4];
	assign mapper_num    = {mapper_hi, hdr_mem[6][7:4]};
	assign submapper     = is_nes20 ? hdr_mem[8] : 8'h00;
	assign prg_ram_shift = is_nes20 ? hdr_mem[10][3:0] : 4'h0;
	assign piano         = is_nes20 && (hdr_mem[15][5:0] == 6'h19);
	assign prg_size      = size_code(hdr_mem[4]);
	assign chr_size      = size_code(hdr_mem[5]);

	assign hdr.mapper_flags = {
		1'b0,
		piano,                                  // 30
		prg_ram_shift,                          // 29:26
		hdr_mem[6][1],                          // 25 battery
		submapper,                              // 24:17
		hdr_mem[6][3],                          // 16 four screen
		(hdr_mem[5] == 8'h00),                  // 15 CHR RAM
		hdr_mem[6][0] ^ hdr.invert_mirroring,   // 14
		chr_size,                               // 13:11
		prg_size,                               // 10:8
		mapper_num                              // 7:0
	};

	// Header fills in order, a new header restarts at byte 0
	a_hdr_index_order: assert property (@(posedge clk)
		hdr.hdr_we |-> ((hdr.hdr_index == '0) || (hdr.hdr_index == next_index)))
		else $error("header write with index %0h out of order", hdr.hdr_index);

endmodule

`default_nettype wire

//--- verilog/ines_header_if.sv
//////////////////////////////
// Link between the load sequencer and the header decoder
// Header bytes go down, decoded fields come back
//////////////////////////////

`timescale 1ns/100ps
`default_nettype none

interface ines_header_if import nes_cart_pkg::*, nes_load_pkg::*; (input wire logic invert_mirroring);

	logic          hdr_we;
	header_index_t hdr_index;
	ines_byte_t    hdr_byte;

	logic          header_ok;      // Magic matches and no trainer
	page_count_t   prg_pages;
	page_count_t   chr_pages;
	mapper_flags_t mapper_flags;

	modport sequencer (output hdr_we, hdr_index, hdr_byte,
	                   input header_ok, prg_pages, chr_pages);

	modport decoder (input hdr_we, hdr_index, hdr_byte, invert_mirroring,
	                 output header_ok, prg_pages, chr_pages, mapper_flags);

endinterface

`default_nettype wire

//--- verilog/nes_load_pkg.sv
//////////////////////////////
// Types describing the loading process itself
// Imported by the sequencer, the header interface and the top level
//////////////////////////////

`default_nettype none

`include "nes_loader_defines.svh"

package nes_load_pkg;

	typedef logic [`ROM_ADDR_W-1:0] rom_addr_t;     // Write address into ROM space
	typedef logic [`ROM_ADDR_W-1:0] byte_count_t;   // Bytes left in current region

	typedef logic [3:0] header_index_t;
	typedef logic [3:0] cheat_index_t;

	// Loader FSM
	typedef enum logic [2:0] {
		S_IDLE,
		S_HEADER,
		S_PRG,
		S_CHR,
		S_CHEAT,
		S_DONE,
		S_ERROR
	} load_state_t;

endpackage

`default_nettype wire

//--- verilog/nes_cart_pkg.sv
//////////////////////////////
// Types describing what a cartridge image contains
// Imported by the loader modules and the header interface
//////////////////////////////

`default_nettype none

package nes_cart_pkg;

	// One byte of header or ROM payload
	typedef logic [7:0] ines_byte_t;

	// PRG or CHR page count from the header
	typedef logic [7:0] page_count_t;

	// Log2 size class of a ROM region, capped at 7
	typedef logic [2:0] size_code_t;

	// Decoded flag word handed to the mapper logic
	typedef logic [31:0] mapper_flags_t;

	// Cheat code layout
	// 127:96 flags, 95:64 address, 63:32 compare, 31:0 replace
	typedef logic [127:0] cheat_code_t;

endpackage

`default_nettype wire

//--- include/nes_loader_defines.svh
//////////////////////////////
// Constants shared by the cartridge loader RTL and its testbench
// Include wherever header sizes, page shifts or the ROM map are needed
//////////////////////////////

`ifndef NES_LOADER_DEFINES_SVH
`define NES_LOADER_DEFINES_SVH

// iNES header layout
`define INES_HEADER_BYTES   16
`define INES_MAGIC0         8'h4E   // N
`define INES_MAGIC1         8'h45   // E
`define INES_MAGIC2         8'h53   // S
`define INES_MAGIC3         8'h1A

// Page sizes as shifts
`define PRG_PAGE_SHIFT      14      // 16 KB
`define CHR_PAGE_SHIFT      13      // 8 KB

// ROM address map
`define ROM_ADDR_W          22
`define CHR_BASE_ADDR       22'h200000

// Cheat downloads
`define CHEAT_FILE_TYPE     8'hFF
`define CHEAT_RECORD_BYTES  16

`endif
